/* flist.f */
hw/dcache_pkg.sv
hw/mem_bus_pkg.sv
hw/dcache_data_array.sv
hw/dcache_tag_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_assertions.sv
verif/tb_dcache.sv

/* Makefile */
VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := tb_dcache
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := sim failed
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_dcache.sv */
`timescale 1ns/10ps
`default_nettype none

// Testbench for the L1 data cache
// Main memory is modeled here, a shadow model predicts every result
module tb_dcache;
    import dcache_pkg::*;
    import mem_bus_pkg::*;

    localparam int INDEX_BITS   = 9;
    localparam int TAG_BITS     = 17 - INDEX_BITS;
    localparam int LINES        = 1 << INDEX_BITS;
    localparam int WORDS        = 1 << 17;
    localparam int NUM_OPS      = 19;
    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        logic       do_reset;
        word_addr_t addr;
        word_t      wdata;
        strb_t      strb;
    } op_t;

    logic     clk     = 1'b0;
    logic     rst     = 1'b1;
    logic     sel     = 1'b0;
    cpu_req_t cpu_req = '0;
    logic     stall;
    word_t    rdata;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp = '0;

    // Main memory model state
    word_t       main_mem [WORDS];
    bit          mem_written [WORDS];
    logic [31:0] lfsr         = 32'ha417ce39;
    logic        mem_busy     = 1'b0;
    logic [1:0]  mem_wait     = '0;
    int          mem_reads    = 0;
    int          mem_writes   = 0;
    word_addr_t  last_rd_addr = '0;
    word_addr_t  last_wb_addr = '0;
    word_t       last_wb_data = '0;

    // Shadow of memory and of the cache lines
    word_t               sh_mem [WORDS];
    bit                  sh_mem_set [WORDS];
    logic [TAG_BITS-1:0] sh_tag [LINES];
    word_t               sh_data [LINES];
    bit                  sh_valid [LINES];
    bit                  sh_dirty [LINES];

    op_t        ops [NUM_OPS];
    word_t      exp_rdata;
    int         exp_reads;
    int         exp_writes;
    word_addr_t exp_wb_addr;
    word_t      exp_wb_data;
    int         checks = 0;
    int         errors = 0;

    dcache_top #(
        .INDEX_BITS(INDEX_BITS)
    ) UUT (
        .clk_i    (clk),
        .rst_i    (rst),
        .sel_i    (sel),
        .req_i    (cpu_req),
        .stall_o  (stall),
        .rdata_o  (rdata),
        .mem_req_o(mem_req),
        .mem_rsp_i(mem_rsp)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // Power-up contents of main memory, unique per word address
    function automatic word_t init_word(input word_addr_t a);
        return ({15'h0, a} * 32'h0001_9e37) ^ 32'hc3a5_5a3c;
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Registered response, ready after 0 to 3 extra cycles
    always @(posedge clk) begin : mem_model
        logic [1:0] latency;
        if (rst) begin
            mem_rsp  <= '0;
            mem_busy <= 1'b0;
            mem_wait <= '0;
        end else if (mem_rsp.ready) begin
            // Transfer completes on this edge
            mem_rsp.ready <= 1'b0;
            mem_busy      <= 1'b0;
            if (mem_req.wstrb == '0) begin
                mem_reads    <= mem_reads + 1;
                last_rd_addr <= mem_req.addr;
            end else begin
                mem_writes                <= mem_writes + 1;
                last_wb_addr              <= mem_req.addr;
                last_wb_data              <= mem_req.wdata;
                main_mem[mem_req.addr]    <= mem_req.wdata;
                mem_written[mem_req.addr] <= 1'b1;
            end
        end else if (mem_req.valid) begin
            if (!mem_busy) begin
                // New request, draw its latency
                lfsr       = lfsr_next(lfsr);
                latency[0] = lfsr[0];
                lfsr       = lfsr_next(lfsr);
                latency[1] = lfsr[0];
            end else begin
                latency = mem_wait;
            end
            mem_busy <= 1'b1;
            if (latency == 2'd0) begin
                mem_rsp.ready <= 1'b1;
                mem_rsp.rdata <= mem_written[mem_req.addr] ? main_mem[mem_req.addr]
                                                           : init_word(mem_req.addr);
            end else begin
                mem_wait <= latency - 2'd1;
            end
        end
    end

    task automatic load_table();
        // do_reset, word address, write data, byte mask (zero for a read)
        ops[0]  = '{1'b0, 17'h00010, 32'h0000_0000, 4'h0};
        ops[1]  = '{1'b0, 17'h00010, 32'h0000_0000, 4'h0};
        ops[2]  = '{1'b0, 17'h00020, 32'hdead_beef, 4'hf};
        ops[3]  = '{1'b0, 17'h00020, 32'h0000_0000, 4'h0};
        ops[4]  = '{1'b0, 17'h00030, 32'h1122_3344, 4'h5};
        ops[5]  = '{1'b0, 17'h00030, 32'h0000_0000, 4'h0};
        ops[6]  = '{1'b0, 17'h00220, 32'h0000_0000, 4'h0};
        ops[7]  = '{1'b0, 17'h00020, 32'h0000_0000, 4'h0};
        ops[8]  = '{1'b0, 17'h00230, 32'ha500_0000, 4'h8};
        ops[9]  = '{1'b0, 17'h00230, 32'hcafe_f00d, 4'hf};
        ops[10] = '{1'b0, 17'h00230, 32'h0000_0000, 4'h0};
        ops[11] = '{1'b0, 17'h00010, 32'h0000_0000, 4'h0};
        ops[12] = '{1'b1, 17'h00010, 32'h0000_0000, 4'h0};
        ops[13] = '{1'b0, 17'h1ff00, 32'h0000_0000, 4'h0};
        ops[14] = '{1'b0, 17'h1ff00, 32'h0bad_f00d, 4'hf};
        ops[15] = '{1'b0, 17'h0ff00, 32'h0000_0000, 4'h0};
        ops[16] = '{1'b0, 17'h1ff00, 32'h0000_0000, 4'h0};
        ops[17] = '{1'b0, 17'h1ff00, 32'h0000_beef, 4'h3};
        ops[18] = '{1'b0, 17'h1ff00, 32'h0000_0000, 4'h0};
    endtask

    // Expected transfers and read data from the cache rules
    task automatic predict_op(input op_t op);
        logic [INDEX_BITS-1:0] idx;
        logic [TAG_BITS-1:0]   tag;
        word_t                 line;
        idx        = op.addr[INDEX_BITS-1:0];
        tag        = op.addr[16:INDEX_BITS];
        exp_reads  = 0;
        exp_writes = 0;
        if (!(sh_valid[idx] && sh_tag[idx] == tag)) begin
            // Dirty victim goes back to memory first
            if (sh_valid[idx] && sh_dirty[idx]) begin
                exp_writes              = 1;
                exp_wb_addr             = {sh_tag[idx], idx};
                exp_wb_data             = sh_data[idx];
                sh_mem[exp_wb_addr]     = sh_data[idx];
                sh_mem_set[exp_wb_addr] = 1'b1;
            end
            // Only full-word writes skip the fetch
            if (op.strb != 4'hf) begin
                exp_reads    = 1;
                sh_data[idx] = sh_mem_set[op.addr] ? sh_mem[op.addr] : init_word(op.addr);
            end
            sh_tag[idx]   = tag;
            sh_valid[idx] = 1'b1;
            sh_dirty[idx] = 1'b0;
        end
        line = sh_data[idx];
        for (int b = 0; b < 4; b++) begin
            if (op.strb[b]) begin
                line[8*b +: 8] = op.wdata[8*b +: 8];
            end
        end
        sh_data[idx] = line;
        if (op.strb != '0) begin
            sh_dirty[idx] = 1'b1;
        end
        exp_rdata = line;
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        sel <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < LINES; i++) begin
            sh_valid[i] = 1'b0;
            sh_dirty[i] = 1'b0;
        end
    endtask

    task automatic run_op(input int n);
        op_t   op;
        int    reads_before;
        int    writes_before;
        int    errors_before;
        string kind;
        op = ops[n];
        if (op.do_reset) begin
            apply_reset();
        end
        predict_op(op);
        errors_before = errors;
        @(posedge clk);
        sel           <= 1'b1;
        cpu_req       <= '{addr: op.addr, wdata: op.wdata, strb: op.strb};
        reads_before  = mem_reads;
        writes_before = mem_writes;
        // Request completes in the cycle stall_o is low
        do begin
            @(negedge clk);
        end while (stall);
        if (op.strb == '0) begin
            check_word("rdata_o", rdata, exp_rdata);
        end
        check_word("mem read count", mem_reads - reads_before, exp_reads);
        check_word("mem write count", mem_writes - writes_before, exp_writes);
        if (exp_writes != 0) begin
            check_word("mem_req_o.addr (write-back)", last_wb_addr, exp_wb_addr);
            check_word("mem_req_o.wdata (write-back)", last_wb_data, exp_wb_data);
        end
        if (exp_reads != 0) begin
            check_word("mem_req_o.addr (fetch)", last_rd_addr, op.addr);
        end
        if (op.strb == '0) begin
            kind = "read";
        end else if (op.strb == 4'hf) begin
            kind = "write";
        end else begin
            kind = "partial write";
        end
        $display("op %0d %s addr %05h%s: %s", n, kind, op.addr,
                 op.do_reset ? " after reset" : "",
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_OPS; n++) begin
            run_op(n);
        end
        @(posedge clk);
        sel <= 1'b0;
        repeat (2) @(posedge clk);
        $display("%0d ops, %0d checks, %0d errors", NUM_OPS, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Worst-case op is well under 40 cycles
    initial begin : watchdog
        repeat (NUM_OPS * 40) @(posedge clk);
        $display("Timeout: the table did not finish within %0d cycles", NUM_OPS * 40);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/dcache_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

// Protocol rules of the cache controller ports
module dcache_assertions (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  sel_i,
    input logic                  stall_i,
    input mem_bus_pkg::mem_req_t mem_req_i,
    input mem_bus_pkg::mem_rsp_t mem_rsp_i
);

    // Request held until the memory takes it
    property req_held_until_ready;
        @(posedge clk_i) disable iff (rst_i)
        (mem_req_i.valid && !mem_rsp_i.ready) |=> $stable(mem_req_i);
    endproperty

    // Write-backs always move the whole word
    property write_full_mask;
        @(posedge clk_i) disable iff (rst_i)
        (mem_req_i.valid && mem_req_i.wstrb != '0) |-> (mem_req_i.wstrb == '1);
    endproperty

    // A finished request leaves the next one stalled
    property done_lasts_one_cycle;
        @(posedge clk_i) disable iff (rst_i)
        (sel_i && !stall_i) |=> (!sel_i || stall_i);
    endproperty

    assert property (req_held_until_ready) else $error("memory request changed before ready");
    assert property (write_full_mask) else $error("memory write without a full byte mask");
    assert property (done_lasts_one_cycle) else $error("request finished twice without a stall");

endmodule

bind dcache_ctrl dcache_assertions u_assertions (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .sel_i    (sel_i),
    .stall_i  (stall_o),
    .mem_req_i(mem_req_o),
    .mem_rsp_i(mem_rsp_i)
);

`default_nettype wire

/* hw/dcache_top.sv */
`timescale 1ns/10ps
`default_nettype none

// L1 data cache, direct-mapped, write-back, one word per line
module dcache_top #(
    parameter int INDEX_BITS = 9
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  sel_i,
    input  dcache_pkg::cpu_req_t  req_i,
    output logic                  stall_o,
    output dcache_pkg::word_t     rdata_o,
    output mem_bus_pkg::mem_req_t mem_req_o,
    input  mem_bus_pkg::mem_rsp_t mem_rsp_i
);
    import dcache_pkg::*;

    localparam int TAG_BITS = $bits(word_addr_t) - INDEX_BITS;

    logic [INDEX_BITS-1:0] tag_rd_index;
    logic [TAG_BITS-1:0]   tag_rd;
    logic                  line_valid;
    logic                  line_dirty;
    logic                  tag_we;
    logic [INDEX_BITS-1:0] tag_wr_index;
    logic [TAG_BITS-1:0]   tag_wr_tag;
    logic                  tag_wr_dirty;

    logic                  data_we;
    logic [INDEX_BITS-1:0] data_wr_index;
    strb_t                 data_wmask;
    word_t                 data_wdata;
    logic [INDEX_BITS-1:0] data_rd_index;
    word_t                 data_rdata;

    dcache_ctrl #(
        .INDEX_BITS(INDEX_BITS)
    ) u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .sel_i          (sel_i),
        .req_i          (req_i),
        .stall_o        (stall_o),
        .rdata_o        (rdata_o),
        .mem_req_o      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i),
        .tag_rd_index_o (tag_rd_index),
        .tag_i          (tag_rd),
        .valid_i        (line_valid),
        .dirty_i        (line_dirty),
        .tag_we_o       (tag_we),
        .tag_wr_index_o (tag_wr_index),
        .tag_wr_tag_o   (tag_wr_tag),
        .tag_wr_dirty_o (tag_wr_dirty),
        .data_we_o      (data_we),
        .data_wr_index_o(data_wr_index),
        .data_wmask_o   (data_wmask),
        .data_wdata_o   (data_wdata),
        .data_rd_index_o(data_rd_index),
        .data_rdata_i   (data_rdata)
    );

    dcache_tag_array #(
        .INDEX_BITS(INDEX_BITS)
    ) u_tag_array (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_index_i(tag_rd_index),
        .tag_o     (tag_rd),
        .valid_o   (line_valid),
        .dirty_o   (line_dirty),
        .we_i      (tag_we),
        .wr_index_i(tag_wr_index),
        .wr_tag_i  (tag_wr_tag),
        .wr_dirty_i(tag_wr_dirty)
    );

    dcache_data_array #(
        .INDEX_BITS(INDEX_BITS)
    ) u_data_array (
        .clk_i     (clk_i),
        .we_i      (data_we),
        .wr_index_i(data_wr_index),
        .wmask_i   (data_wmask),
        .wdata_i   (data_wdata),
        .rd_index_i(data_rd_index),
        .rdata_o   (data_rdata)
    );

endmodule

`default_nettype wire

/* hw/dcache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

// Cache controller
// Looks up the line, writes back a dirty victim, fetches on read or
// partial-write misses, then fills or updates the arrays
module dcache_ctrl #(
    parameter int INDEX_BITS = 9,
    localparam int TAG_BITS = 17 - INDEX_BITS
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Processor side
    input  logic                  sel_i,
    input  dcache_pkg::cpu_req_t  req_i,
    output logic                  stall_o,
    output dcache_pkg::word_t     rdata_o,
    // Memory side
    output mem_bus_pkg::mem_req_t mem_req_o,
    input  mem_bus_pkg::mem_rsp_t mem_rsp_i,
    // Tag array
    output logic [INDEX_BITS-1:0] tag_rd_index_o,
    input  logic [TAG_BITS-1:0]   tag_i,
    input  logic                  valid_i,
    input  logic                  dirty_i,
    output logic                  tag_we_o,
    output logic [INDEX_BITS-1:0] tag_wr_index_o,
    output logic [TAG_BITS-1:0]   tag_wr_tag_o,
    output logic                  tag_wr_dirty_o,
    // Data array
    output logic                  data_we_o,
    output logic [INDEX_BITS-1:0] data_wr_index_o,
    output dcache_pkg::strb_t     data_wmask_o,
    output dcache_pkg::word_t     data_wdata_o,
    output logic [INDEX_BITS-1:0] data_rd_index_o,
    input  dcache_pkg::word_t     data_rdata_i
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FETCH,
        WRITE,
        DONE
    } state_t;

    state_t state_q, state_d;

    logic [INDEX_BITS-1:0] req_index;
    logic [TAG_BITS-1:0]   req_tag;
    logic                  is_write;
    logic                  need_fetch;
    logic                  hit;
    state_t                miss_state;
    word_t                 merged_word;

    // Memory request payload
    word_addr_t mem_addr_q, mem_addr_d;
    word_t      mem_wdata_q, mem_wdata_d;
    strb_t      mem_wstrb_q, mem_wstrb_d;

    word_t rdata_q, rdata_d;

    // Registered array write strobe
    logic                  wr_en_q;
    logic [INDEX_BITS-1:0] wr_index_q;
    logic [TAG_BITS-1:0]   wr_tag_q;
    logic                  wr_dirty_q;
    strb_t                 wr_mask_q;
    word_t                 wr_data_q;

    assign req_index  = req_i.addr[INDEX_BITS-1:0];
    assign req_tag    = req_i.addr[$bits(word_addr_t)-1:INDEX_BITS];
    assign is_write   = |req_i.strb;
    // Reads and partial writes need the word from memory
    assign need_fetch = ~&req_i.strb;
    assign hit        = valid_i && (tag_i == req_tag);
    assign miss_state = need_fetch ? FETCH : WRITE;

    // Processor bytes laid over the fetched word
    always_comb begin
        merged_word = mem_rsp_i.rdata;
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (req_i.strb[b]) begin
                merged_word[8*b +: 8] = req_i.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        state_d     = state_q;
        mem_addr_d  = mem_addr_q;
        mem_wdata_d = mem_wdata_q;
        mem_wstrb_d = mem_wstrb_q;
        rdata_d     = rdata_q;
        case (state_q)
            IDLE: begin
                if (sel_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    if (is_write) begin
                        state_d = WRITE;
                    end else begin
                        state_d = DONE;
                        rdata_d = data_rdata_i;
                    end
                end else if (valid_i && dirty_i) begin
                    // Victim goes out under its old tag
                    state_d     = WRITEBACK;
                    mem_addr_d  = {tag_i, req_index};
                    mem_wdata_d = data_rdata_i;
                    mem_wstrb_d = '1;
                end else begin
                    state_d     = miss_state;
                    mem_addr_d  = req_i.addr;
                    mem_wstrb_d = '0;
                end
            end
            WRITEBACK: begin
                if (mem_rsp_i.ready) begin
                    state_d     = miss_state;
                    mem_addr_d  = req_i.addr;
                    mem_wstrb_d = '0;
                end
            end
            FETCH: begin
                if (mem_rsp_i.ready) begin
                    state_d = WRITE;
                    rdata_d = mem_rsp_i.rdata;
                end
            end
            WRITE: begin
                state_d = DONE;
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            wr_en_q <= 1'b0;
        end else begin
            state_q <= state_d;
            wr_en_q <= (state_d == WRITE);
        end
    end

    always_ff @(posedge clk_i) begin
        mem_addr_q  <= mem_addr_d;
        mem_wdata_q <= mem_wdata_d;
        mem_wstrb_q <= mem_wstrb_d;
        rdata_q     <= rdata_d;
    end

    // Write port contents, loaded on entry to WRITE
    always_ff @(posedge clk_i) begin
        if (state_d == WRITE) begin
            wr_index_q <= req_index;
            wr_tag_q   <= req_tag;
            wr_dirty_q <= is_write;
            if (state_q == FETCH) begin
                wr_data_q <= merged_word;
                wr_mask_q <= '1;
            end else begin
                wr_data_q <= req_i.wdata;
                wr_mask_q <= req_i.strb;
            end
        end
    end

    assign stall_o = sel_i && (state_q != DONE);
    assign rdata_o = rdata_q;

    assign mem_req_o.valid = (state_q == WRITEBACK) || (state_q == FETCH);
    assign mem_req_o.addr  = mem_addr_q;
    assign mem_req_o.wdata = mem_wdata_q;
    assign mem_req_o.wstrb = mem_wstrb_q;

    assign tag_rd_index_o  = req_index;
    assign tag_we_o        = wr_en_q;
    assign tag_wr_index_o  = wr_index_q;
    assign tag_wr_tag_o    = wr_tag_q;
    assign tag_wr_dirty_o  = wr_dirty_q;

    assign data_rd_index_o = req_index;
    assign data_we_o       = wr_en_q;
    assign data_wr_index_o = wr_index_q;
    assign data_wmask_o    = wr_mask_q;
    assign data_wdata_o    = wr_data_q;

endmodule

`default_nettype wire

/* hw/dcache_tag_array.sv */
`timescale 1ns/10ps
`default_nettype none

// Tag store with per-line valid and dirty bits
module dcache_tag_array #(
    parameter int INDEX_BITS = 9,
    localparam int TAG_BITS = 17 - INDEX_BITS
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Lookup port, combinational
    input  logic [INDEX_BITS-1:0] rd_index_i,
    output logic [TAG_BITS-1:0]   tag_o,
    output logic                  valid_o,
    output logic                  dirty_o,
    // Fill / update port
    input  logic                  we_i,
    input  logic [INDEX_BITS-1:0] wr_index_i,
    input  logic [TAG_BITS-1:0]   wr_tag_i,
    input  logic                  wr_dirty_i
);
    localparam int LINES = 1 << INDEX_BITS;

    logic [TAG_BITS-1:0] tag_q [LINES];
    logic [LINES-1:0]    valid_q;
    logic [LINES-1:0]    dirty_q;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q[wr_index_i] <= wr_tag_i;
        end
    end

    // Line state, cleared on reset so every slot misses
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we_i) begin
            valid_q[wr_index_i] <= 1'b1;
            dirty_q[wr_index_i] <= wr_dirty_i;
        end
    end

    assign tag_o   = tag_q[rd_index_i];
    assign valid_o = valid_q[rd_index_i];
    assign dirty_o = dirty_q[rd_index_i];

endmodule

`default_nettype wire

/* hw/dcache_data_array.sv */
`timescale 1ns/10ps
`default_nettype none

// Line data storage, one word per line
// One write port with byte mask, one read port with registered output
module dcache_data_array #(
    parameter int INDEX_BITS = 9
) (
    input  logic                  clk_i,
    input  logic                  we_i,
    input  logic [INDEX_BITS-1:0] wr_index_i,
    input  dcache_pkg::strb_t     wmask_i,
    input  dcache_pkg::word_t     wdata_i,
    input  logic [INDEX_BITS-1:0] rd_index_i,
    output dcache_pkg::word_t     rdata_o
);
    import dcache_pkg::*;

    localparam int LINES = 1 << INDEX_BITS;
    localparam int BYTES = $bits(strb_t);

    word_t mem_q [LINES];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wmask_i[b]) begin
                    mem_q[wr_index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read before write on a shared index
    always_ff @(posedge clk_i) begin
        rdata_o <= mem_q[rd_index_i];
    end

endmodule

`default_nettype wire

/* hw/mem_bus_pkg.sv */
`default_nettype none

// Memory-side port of the cache, a single valid/ready channel
package mem_bus_pkg;

    import dcache_pkg::word_addr_t;
    import dcache_pkg::word_t;
    import dcache_pkg::strb_t;

    // Request, held stable until ready
    // wstrb of zero is a read, writes carry all ones
    typedef struct packed {
        logic       valid;
        word_addr_t addr;
        word_t      wdata;
        strb_t      wstrb;
    } mem_req_t;

    // Response, rdata is sampled in the ready cycle
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* hw/dcache_pkg.sv */
`default_nettype none

// Processor-side types of the L1 data cache
package dcache_pkg;

    // One data word as seen by the core
    typedef logic [31:0] word_t;

    // Byte mask, one bit per byte lane
    // All zeros marks a read
    typedef logic [3:0] strb_t;

    // Word address, byte address bits 18 down to 2
    typedef logic [16:0] word_addr_t;

    // Request held by the core while stall_o is high
    typedef struct packed {
        word_addr_t addr;
        word_t      wdata;
        strb_t      strb;
    } cpu_req_t;

endpackage

`default_nettype wire
